// ==== bench/mat_mul_trace.txt ====
# cmd addr value (hex). A/B load operand word addr, S/T start one or two multiplies
# R reads result row addr and compares it with value; element 0 in the low bits
# Result memory is zero after reset
R 0 0
R 3 0
# Identity A times B gives the B rows
A 0 00000001
A 1 00000100
A 2 00010000
A 3 01000000
B 0 04030201
B 1 08070605
B 2 0c0b0a09
B 3 100f0e0d
S
R 0 00004000030000200001
R 1 00008000070000600005
R 2 0000c0000b0000a00009
R 3 000100000f0000e0000d
# General A with the same B
A 0 03020001
A 1 01000102
A 2 02010300
A 3 00030201
S
R 0 00024000200001c00018
R 1 0004c00046000400003a
R 2 000440003e0003800032
R 3 0002c00026000200001a
# Identity B, two multiplies back to back
B 0 00000001
B 1 00000100
B 2 00010000
B 3 01000000
T
R 0 00001000000000200001
R 1 00002000030000100000
R 2 00003000010000000002
R 3 00000000020000100003
# All operands at maximum
A 0 ffffffff
A 1 ffffffff
A 2 ffffffff
A 3 ffffffff
B 0 ffffffff
B 1 ffffffff
B 2 ffffffff
B 3 ffffffff
S
R 0 3f8043f8043f8043f804
R 3 3f8043f8043f8043f804

// ==== files.f ====
hdl/mat_mul_pkg.sv
hdl/tile_ram.sv
hdl/operand_fetch.sv
hdl/mac_array.sv
hdl/result_drain.sv
hdl/mat_mul_top.sv
bench/mat_mul_chk.sv
bench/mat_mul_tb.sv

// ==== bench/mat_mul_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mat_mul_tb import mat_mul_pkg::*; ();

  logic     clk;
  logic     reset;
  logic     load_en;
  logic     read_en;
  addr_t    host_addr;
  op_row_t  host_data;
  logic     we_a;
  logic     we_b;
  logic     start_mat_mul;
  logic     done_mat_mul;
  res_row_t data_from_out_mat;
  integer   seed;

  mat_mul_top DUT (
    .clk               (clk),
    .reset             (reset),
    .load_en           (load_en),
    .read_en           (read_en),
    .host_addr         (host_addr),
    .host_data         (host_data),
    .we_a              (we_a),
    .we_b              (we_b),
    .start_mat_mul     (start_mat_mul),
    .done_mat_mul      (done_mat_mul),
    .data_from_out_mat (data_from_out_mat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name,
                             input logic [$bits(res_row_t)-1:0] actual,
                             input logic [$bits(res_row_t)-1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
      end_with_failure();
    end
  endtask

  // Bound protocol assertions end the run at their first failure
  always @(negedge clk) begin
    if (DUT.u_chk.fail_count != 0) begin
      $display("A protocol assertion in the bound checker failed");
      end_with_failure();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host driver
  //////////////////////////////////////////////////////////////////////

  task automatic idle_gap();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) @(posedge clk);
  endtask

  task automatic write_operand(input logic to_b, input addr_t addr, input op_row_t data);
    @(posedge clk);
    load_en   <= 1'b1;
    we_a      <= !to_b;
    we_b      <= to_b;
    host_addr <= addr;
    host_data <= data;
    @(posedge clk);
    load_en <= 1'b0;
    we_a    <= 1'b0;
    we_b    <= 1'b0;
  endtask

  // Returns at the edge that samples the start
  task automatic pulse_start();
    @(posedge clk);
    start_mat_mul <= 1'b1;
    @(posedge clk);
    start_mat_mul <= 1'b0;
  endtask

  task automatic wait_for_done(input int expected_cycles);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    // Generous bound against a stuck pipeline
    while (!seen && cycles < 100) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      seen = done_mat_mul;
    end
    if (!seen) begin
      $display("Timeout: done_mat_mul never pulsed within %0d cycles", cycles);
      end_with_failure();
    end
    check_value("done_mat_mul latency", cycles, expected_cycles);
  endtask

  task automatic run_multiply();
    pulse_start();
    wait_for_done(2 * TILE_N + 3);
    // Exactly one pulse
    @(posedge clk);
    @(negedge clk);
    check_value("done_mat_mul", done_mat_mul, 1'b0);
  endtask

  // Second start lands on the first edge with fetch idle
  task automatic run_two_multiplies();
    pulse_start();
    repeat (TILE_N - 1) @(posedge clk);
    pulse_start();
    wait_for_done(TILE_N + 2);
    wait_for_done(TILE_N + 1);
  endtask

  // Data is valid three edges after the request
  task automatic read_row(input addr_t addr, input res_row_t expected);
    @(posedge clk);
    read_en   <= 1'b1;
    host_addr <= addr;
    @(posedge clk);
    read_en <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("data_from_out_mat", data_from_out_mat, expected);
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 8'h0a && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Trace player
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                          fd;
    int                          n;
    int                          cmd_count;
    logic [7:0]                  cmd;
    logic [31:0]                 addr_val;
    logic [$bits(res_row_t)-1:0] data_val;
    clk_init: begin
      reset         = 1'b1;
      load_en       = 1'b0;
      read_en       = 1'b0;
      host_addr     = '0;
      host_data     = '0;
      we_a          = 1'b0;
      we_b          = 1'b0;
      start_mat_mul = 1'b0;
    end
    seed      = 32'hb5d6;
    cmd_count = 0;
    fd = $fopen("bench/mat_mul_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file bench/mat_mul_trace.txt");
      end_with_failure();
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    while ($fscanf(fd, " %c", cmd) == 1) begin
      if (cmd == "#") begin
        skip_line(fd);
      end else begin
        cmd_count++;
        if (cmd == "A" || cmd == "B" || cmd == "R") begin
          n = $fscanf(fd, "%h %h", addr_val, data_val);
          if (n != 2) begin
            $display("Trace line for command %c is missing its address or data", cmd);
            end_with_failure();
          end
        end
        idle_gap();
        case (cmd)
          "A": write_operand(1'b0, addr_t'(addr_val), op_row_t'(data_val));
          "B": write_operand(1'b1, addr_t'(addr_val), op_row_t'(data_val));
          "S": run_multiply();
          "T": run_two_multiplies();
          "R": read_row(addr_t'(addr_val), res_row_t'(data_val));
          default: begin
            $display("Unknown trace command %c", cmd);
            end_with_failure();
          end
        endcase
      end
    end
    $fclose(fd);

    if (cmd_count == 0) begin
      $display("The trace file held no commands");
      end_with_failure();
    end else if (DUT.u_chk.fail_count != 0) begin
      $display("A protocol assertion in the bound checker failed");
      end_with_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== bench/mat_mul_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module mat_mul_chk import mat_mul_pkg::*; (
  input logic clk,
  input logic reset,
  input logic start_mat_mul,
  input logic fetch_busy,
  input logic done_mat_mul,
  input logic c_we,
  input logic read_en_q
);

  // Failed properties so far, watched by the testbench
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////////////////////////

  // Done is a single-cycle strobe
  done_one_cycle: assert property (@(posedge clk) disable iff (reset)
    done_mat_mul |=> !done_mat_mul)
    else begin
      $error("done_mat_mul high on two consecutive cycles");
      fail_count++;
    end

  // Accepted start at edge 0, done registered at edge 2N+3
  done_latency: assert property (@(posedge clk) disable iff (reset)
    (start_mat_mul && !fetch_busy)
      |-> ##(2 * TILE_N + 3) !done_mat_mul ##1 done_mat_mul)
    else begin
      $error("done_mat_mul not seen 2N+3 cycles after an accepted start");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // Result memory port
  //////////////////////////////////////////////////////////////////////

  // Host reads only while the drain leaves the port alone
  no_read_during_drain: assert property (@(posedge clk) disable iff (reset)
    read_en_q |-> !c_we)
    else begin
      $error("Result memory written while a host read was registered");
      fail_count++;
    end

endmodule

bind mat_mul_top mat_mul_chk u_chk (
  .clk           (clk),
  .reset         (reset),
  .start_mat_mul (start_mat_mul),
  .fetch_busy    (u_fetch.busy),
  .done_mat_mul  (done_mat_mul),
  .c_we          (c_we),
  .read_en_q     (u_drain.read_en_q)
);

`default_nettype wire

// ==== hdl/mat_mul_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mat_mul_top import mat_mul_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     load_en,
  input  logic     read_en,
  input  addr_t    host_addr,
  input  op_row_t  host_data,
  input  logic     we_a,
  input  logic     we_b,
  input  logic     start_mat_mul,
  output logic     done_mat_mul,
  output res_row_t data_from_out_mat
);

  // Operand side
  addr_t    a_addr;
  addr_t    b_addr;
  op_row_t  op_wdata;
  logic     a_we;
  logic     b_we;
  op_row_t  a_col;
  op_row_t  b_row;
  logic     step_valid;
  logic     step_last;

  // Result side
  res_row_t snap_rows [TILE_N];
  logic     snap_valid;
  addr_t    c_addr;
  res_row_t c_wdata;
  logic     c_we;
  res_row_t c_rdata;

  //////////////////////////////////////////////////////////////////////
  // Fetch and operand memories
  //////////////////////////////////////////////////////////////////////

  operand_fetch u_fetch (
    .clk           (clk),
    .reset         (reset),
    .load_en       (load_en),
    .host_addr     (host_addr),
    .host_data     (host_data),
    .we_a          (we_a),
    .we_b          (we_b),
    .start_mat_mul (start_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .wdata         (op_wdata),
    .a_we          (a_we),
    .b_we          (b_we),
    .step_valid    (step_valid),
    .step_last     (step_last)
  );

  // A holds one column per word
  tile_ram #(.word_t(op_row_t)) u_ram_a (
    .clk   (clk),
    .we    (a_we),
    .addr  (a_addr),
    .wdata (op_wdata),
    .rdata (a_col)
  );

  // B holds one row per word
  tile_ram #(.word_t(op_row_t)) u_ram_b (
    .clk   (clk),
    .we    (b_we),
    .addr  (b_addr),
    .wdata (op_wdata),
    .rdata (b_row)
  );

  //////////////////////////////////////////////////////////////////////
  // MAC array, drain and result memory
  //////////////////////////////////////////////////////////////////////

  mac_array u_mac (
    .clk        (clk),
    .reset      (reset),
    .a_col      (a_col),
    .b_row      (b_row),
    .step_valid (step_valid),
    .step_last  (step_last),
    .snap_rows  (snap_rows),
    .snap_valid (snap_valid)
  );

  result_drain u_drain (
    .clk               (clk),
    .reset             (reset),
    .snap_rows         (snap_rows),
    .snap_valid        (snap_valid),
    .read_en           (read_en),
    .host_addr         (host_addr),
    .c_rdata           (c_rdata),
    .c_addr            (c_addr),
    .c_wdata           (c_wdata),
    .c_we              (c_we),
    .done_mat_mul      (done_mat_mul),
    .data_from_out_mat (data_from_out_mat)
  );

  tile_ram #(.word_t(res_row_t)) u_ram_c (
    .clk   (clk),
    .we    (c_we),
    .addr  (c_addr),
    .wdata (c_wdata),
    .rdata (c_rdata)
  );

endmodule

`default_nettype wire

// ==== hdl/result_drain.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_drain import mat_mul_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  res_row_t snap_rows [TILE_N],
  input  logic     snap_valid,
  input  logic     read_en,
  input  addr_t    host_addr,
  input  res_row_t c_rdata,
  output addr_t    c_addr,
  output res_row_t c_wdata,
  output logic     c_we,
  output logic     done_mat_mul,
  output res_row_t data_from_out_mat
);

  res_row_t rows_q [TILE_N];
  addr_t    row_cnt;
  logic     active;
  logic     done_pend;
  logic     read_en_q;
  addr_t    read_addr_q;
  logic     read_vld_q;

  //////////////////////////////////////////////////////////////////////
  // Drain of the snapshot into the result memory
  //////////////////////////////////////////////////////////////////////

  // Row 0 goes straight from the snapshot, the rest from the copy
  assign c_we    = snap_valid || active;
  assign c_addr  = c_we ? row_cnt : read_addr_q;
  assign c_wdata = active ? rows_q[row_cnt] : snap_rows[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      active       <= 1'b0;
      row_cnt      <= '0;
      done_pend    <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      if (snap_valid) begin
        active  <= 1'b1;
        row_cnt <= addr_t'(1);
      end else if (active) begin
        row_cnt <= row_cnt + 1'b1;
        if (row_cnt == LAST_IDX) begin
          active  <= 1'b0;
          row_cnt <= '0;
        end
      end
      done_pend    <= active && (row_cnt == LAST_IDX);
      done_mat_mul <= done_pend;
    end
  end

  always_ff @(posedge clk) begin
    if (snap_valid) begin
      rows_q <= snap_rows;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host read path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      read_en_q         <= 1'b0;
      read_addr_q       <= '0;
      read_vld_q        <= 1'b0;
      data_from_out_mat <= '0;
    end else begin
      read_en_q   <= read_en;
      read_addr_q <= host_addr;
      // Read only counts when the drain left the port free
      read_vld_q  <= read_en_q && !c_we;
      if (read_vld_q) begin
        data_from_out_mat <= c_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mac_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_array import mat_mul_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  op_row_t  a_col,
  input  op_row_t  b_row,
  input  logic     step_valid,
  input  logic     step_last,
  output res_row_t snap_rows [TILE_N],
  output logic     snap_valid
);

  acc_t acc      [TILE_N][TILE_N];
  acc_t acc_next [TILE_N][TILE_N];
  logic first_q;

  //////////////////////////////////////////////////////////////////////
  // Outer product of column k of A and row k of B
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < TILE_N; i++) begin
      for (int j = 0; j < TILE_N; j++) begin
        // First step of a multiply starts from zero
        acc_next[i][j] = (first_q ? acc_t'(0) : acc[i][j])
                       + acc_t'(a_col[i]) * acc_t'(b_row[j]);
      end
    end
  end

  // Control
  always_ff @(posedge clk) begin
    if (reset) begin
      first_q    <= 1'b1;
      snap_valid <= 1'b0;
    end else begin
      if (step_valid) begin
        first_q <= step_last;
      end
      snap_valid <= step_valid && step_last;
    end
  end

  // Accumulators and result snapshot
  always_ff @(posedge clk) begin
    if (step_valid) begin
      acc <= acc_next;
    end
    if (step_valid && step_last) begin
      for (int i = 0; i < TILE_N; i++) begin
        for (int j = 0; j < TILE_N; j++) begin
          snap_rows[i][j] <= acc_next[i][j];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_fetch import mat_mul_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    load_en,
  input  addr_t   host_addr,
  input  op_row_t host_data,
  input  logic    we_a,
  input  logic    we_b,
  input  logic    start_mat_mul,
  output addr_t   a_addr,
  output addr_t   b_addr,
  output op_row_t wdata,
  output logic    a_we,
  output logic    b_we,
  output logic    step_valid,
  output logic    step_last
);

  logic  load_q;
  addr_t host_addr_q;
  logic  busy;
  addr_t k;
  addr_t fetch_addr;
  logic  issue_valid;
  logic  issue_last;

  //////////////////////////////////////////////////////////////////////
  // Host access, one register stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      load_q      <= 1'b0;
      host_addr_q <= '0;
      a_we        <= 1'b0;
      b_we        <= 1'b0;
    end else begin
      load_q      <= load_en;
      host_addr_q <= host_addr;
      a_we        <= we_a && load_en;
      b_we        <= we_b && load_en;
    end
  end

  always_ff @(posedge clk) begin
    wdata <= host_data;
  end

  //////////////////////////////////////////////////////////////////////
  // Step sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      k           <= '0;
      fetch_addr  <= '0;
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      step_valid  <= 1'b0;
      step_last   <= 1'b0;
    end else begin
      // Start is dropped while a fetch is running
      if (!busy && start_mat_mul) begin
        busy <= 1'b1;
        k    <= '0;
      end else if (busy) begin
        fetch_addr <= k;
        k          <= k + 1'b1;
        if (k == LAST_IDX) begin
          busy <= 1'b0;
        end
      end
      issue_valid <= busy;
      issue_last  <= busy && (k == LAST_IDX);
      // Line up with the RAM read data
      step_valid  <= issue_valid;
      step_last   <= issue_last;
    end
  end

  // Host address wins while loading
  assign a_addr = load_q ? host_addr_q : fetch_addr;
  assign b_addr = load_q ? host_addr_q : fetch_addr;

endmodule

`default_nettype wire

// ==== hdl/tile_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module tile_ram import mat_mul_pkg::*; #(
  parameter type word_t = op_row_t
) (
  input  logic  clk,
  input  logic  we,
  input  addr_t addr,
  input  word_t wdata,
  output word_t rdata
);

  word_t mem [MEM_DEPTH];

  // Power-up contents are zero, so an unwritten row reads back as zero
  initial begin
    for (int w = 0; w < MEM_DEPTH; w++) begin
      mem[w] = '0;
    end
  end

  // Single port, write-first, one cycle read latency
  always @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mat_mul_pkg.sv ====
`default_nettype none

package mat_mul_pkg;

  //////////////////////////////////////////////////////////////////////
  // Tile sizes
  //////////////////////////////////////////////////////////////////////

  localparam int TILE_N = 4;
  localparam int ELEM_W = 8;
  localparam int ACC_W  = 20;
  localparam int ADDR_W = 2;

  // One word per row, so the memories are exactly TILE_N deep
  localparam int MEM_DEPTH = 2 ** ADDR_W;

  //////////////////////////////////////////////////////////////////////
  // Element and row types
  //////////////////////////////////////////////////////////////////////

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [ACC_W-1:0]  acc_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Element 0 sits in the low bits
  typedef elem_t [TILE_N-1:0] op_row_t;
  typedef acc_t  [TILE_N-1:0] res_row_t;

  // Index of the last step and the last result row
  localparam addr_t LAST_IDX = addr_t'(TILE_N - 1);

endpackage

`default_nettype wire
